//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the output for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module tb_dma_endpoint \
    -o tb_dma_endpoint

output=$(./obj_dir/tb_dma_endpoint)
echo "$output"

if echo "$output" | grep -qF 'All tests passed!'; then
    exit 0
else
    exit 1
fi

//--- src/bus_register_front.sv
`timescale 1ns/100ps
`default_nettype none

`include "dma_endpoint_settings.svh"

module bus_register_front
    import dma_endpoint_pkg::*;
(
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire bus_request_t  bus,
    output      reg_command_t  bus_write,
    output      reg_command_t  bus_read_address,
    input  wire bus_response_t read_result,
    output      bus_response_t bus_response
);

    localparam int address_width = $clog2(`DMA_REG_DEPTH);
    localparam logic [31:0] window_bytes = 32'(4 * `DMA_REG_DEPTH);

    logic [31:0]              offset;
    logic                     in_window;
    logic [address_width-1:0] word_index;

    // Addresses below the base wrap around to large offsets and fall outside the window
    assign offset = bus.address - `DMA_BASE_ADDRESS;
    assign in_window = offset < window_bytes;
    assign word_index = offset[address_width+1:2];

    always_ff @(posedge clock) begin
        if (!reset) begin
            bus_write.valid <= 1'b0;
            bus_read_address.valid <= 1'b0;
        end else begin
            bus_write.valid <= bus.write_strobe && in_window;
            bus_read_address.valid <= bus.read_strobe && in_window;
        end
    end

    always_ff @(posedge clock) begin
        bus_write.destination <= word_index;
        bus_write.data <= bus.write_data;
        bus_read_address.destination <= word_index;
        bus_read_address.data <= '0;
    end

    // Read data comes back from the sequencer already in bus format
    assign bus_response = read_result;

endmodule

`default_nettype wire

//--- src/dma_endpoint_pkg.sv
`default_nettype none

`include "dma_endpoint_settings.svh"

package dma_endpoint_pkg;

    // Memory-mapped bus as seen by the endpoint, one strobe per access
    typedef struct packed {
        logic        write_strobe;
        logic        read_strobe;
        logic [31:0] address;
        logic [31:0] write_data;
    } bus_request_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } bus_response_t;

    // The destination is a channel number for stream writes and a word index for bus accesses
    typedef struct packed {
        logic                              valid;
        logic [$clog2(`DMA_REG_DEPTH)-1:0] destination;
        logic [31:0]                       data;
    } reg_command_t;

    typedef struct packed {
        logic                              valid;
        logic [$clog2(`DMA_REG_DEPTH)-1:0] channel;
    } read_request_t;

    typedef struct packed {
        logic                       valid;
        logic [`DMA_DATA_WIDTH-1:0] data;
    } read_response_t;

    typedef struct packed {
        logic                              valid;
        logic [$clog2(`DMA_REG_DEPTH)-1:0] channel;
        logic [$clog2(`DMA_REG_DEPTH)-1:0] target;
    } io_mapping_t;

    typedef struct packed {
        logic                              valid;
        logic [$clog2(`DMA_REG_DEPTH)-1:0] address;
        logic [`DMA_DATA_WIDTH-1:0]        data;
    } reg_write_t;

    typedef enum logic [1:0] {
        idle,
        bus_read,
        wait_read,
        stream_read
    } read_state_t;

endpackage

`default_nettype wire

//--- src/dma_endpoint_settings.svh
`ifndef DMA_ENDPOINT_SETTINGS_SVH
`define DMA_ENDPOINT_SETTINGS_SVH

// Geometry of the processor register file

// Number of registers, one word each
// The register address width is the base-2 logarithm of this value
`define DMA_REG_DEPTH 64

// Width of one register in bits
`define DMA_DATA_WIDTH 20

// Bus side constants

// Width of the active channel count in the configuration word
`define DMA_CHANNEL_BITS 4

// First byte address of the register window on the bus
`define DMA_BASE_ADDRESS 32'h43c00000

`endif

//--- src/dma_endpoint_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dma_endpoint_settings.svh"

module dma_endpoint_top
    import dma_endpoint_pkg::*;
(
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire bus_request_t                 bus,
    output      bus_response_t                bus_response,
    input  wire io_mapping_t                  io_mapping,
    input  wire reg_command_t                 stream_write,
    input  wire read_request_t                read_request,
    output      logic                         read_request_ready,
    output      read_response_t               read_response,
    output      logic [`DMA_CHANNEL_BITS-1:0] n_channels,
    output      logic [15:0]                  program_size
);

    localparam int address_width = $clog2(`DMA_REG_DEPTH);

    reg_command_t               bus_write;
    reg_command_t               bus_read_address;
    bus_response_t              read_result;
    logic [address_width-1:0]   write_channel;
    logic [address_width-1:0]   write_target;
    logic [address_width-1:0]   read_channel;
    logic [address_width-1:0]   read_target;
    reg_write_t                 reg_write;
    logic [address_width-1:0]   reg_read_address;
    logic [`DMA_DATA_WIDTH-1:0] reg_read_data;

    bus_register_front u_front (
        .clock            (clock),
        .reset            (reset),
        .bus              (bus),
        .bus_write        (bus_write),
        .bus_read_address (bus_read_address),
        .read_result      (read_result),
        .bus_response     (bus_response)
    );

    io_translation_table u_table (
        .clock         (clock),
        .reset         (reset),
        .io_mapping    (io_mapping),
        .write_channel (write_channel),
        .write_target  (write_target),
        .read_channel  (read_channel),
        .read_target   (read_target)
    );

    dma_write_router u_router (
        .clock          (clock),
        .reset          (reset),
        .stream_write   (stream_write),
        .bus_write      (bus_write),
        .lookup_channel (write_channel),
        .lookup_target  (write_target),
        .reg_write      (reg_write),
        .n_channels     (n_channels),
        .program_size   (program_size)
    );

    dma_read_sequencer u_sequencer (
        .clock              (clock),
        .reset              (reset),
        .bus_read_address   (bus_read_address),
        .read_request       (read_request),
        .read_request_ready (read_request_ready),
        .lookup_channel     (read_channel),
        .lookup_target      (read_target),
        .reg_read_address   (reg_read_address),
        .reg_read_data      (reg_read_data),
        .n_channels         (n_channels),
        .program_size       (program_size),
        .read_result        (read_result),
        .read_response      (read_response)
    );

    register_file u_register_file (
        .clock        (clock),
        .reset        (reset),
        .reg_write    (reg_write),
        .read_address (reg_read_address),
        .read_data    (reg_read_data)
    );

endmodule

`default_nettype wire

//--- src/dma_read_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "dma_endpoint_settings.svh"

module dma_read_sequencer
    import dma_endpoint_pkg::*;
(
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire reg_command_t                      bus_read_address,
    input  wire read_request_t                     read_request,
    output      logic                              read_request_ready,
    output      logic [$clog2(`DMA_REG_DEPTH)-1:0] lookup_channel,
    input  wire logic [$clog2(`DMA_REG_DEPTH)-1:0] lookup_target,
    output      logic [$clog2(`DMA_REG_DEPTH)-1:0] reg_read_address,
    input  wire logic [`DMA_DATA_WIDTH-1:0]        reg_read_data,
    input  wire logic [`DMA_CHANNEL_BITS-1:0]      n_channels,
    input  wire logic [15:0]                       program_size,
    output      bus_response_t                     read_result,
    output      read_response_t                    read_response
);

    read_state_t state;
    logic        stream_start;
    logic        bus_start;
    logic        config_read;
    logic [31:0] config_word;
    logic [31:0] register_word;

    // New reads are only taken while nothing is in flight
    assign read_request_ready = (state == idle);

    // A request for channel 0 is consumed without a response
    assign stream_start = read_request_ready && read_request.valid && (read_request.channel != '0);
    assign bus_start = read_request_ready && !stream_start && bus_read_address.valid;

    assign lookup_channel = read_request.channel;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            config_read <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (stream_start) begin
                        state <= wait_read;
                        config_read <= 1'b0;
                    end else if (bus_start) begin
                        state <= bus_read;
                        config_read <= (bus_read_address.destination == '0);
                    end
                end
                bus_read: state <= idle;
                // The extra cycle lines the stream response up with the processor read latency
                wait_read: state <= stream_read;
                stream_read: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Stream channels go through the table, bus reads address the register file directly
    always_ff @(posedge clock) begin
        if (stream_start) begin
            reg_read_address <= lookup_target;
        end else if (bus_start) begin
            reg_read_address <= bus_read_address.destination;
        end
    end

    assign config_word = {program_size, {(16 - `DMA_CHANNEL_BITS){1'b0}}, n_channels};
    assign register_word = {{(32 - `DMA_DATA_WIDTH){1'b0}}, reg_read_data};

    always_comb begin
        read_result.valid = (state == bus_read);
        read_result.data = config_read ? config_word : register_word;
        read_response.valid = (state == stream_read);
        read_response.data = reg_read_data;
    end

endmodule

`default_nettype wire

//--- src/dma_write_router.sv
`timescale 1ns/100ps
`default_nettype none

`include "dma_endpoint_settings.svh"

module dma_write_router
    import dma_endpoint_pkg::*;
(
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire reg_command_t                      stream_write,
    input  wire reg_command_t                      bus_write,
    output      logic [$clog2(`DMA_REG_DEPTH)-1:0] lookup_channel,
    input  wire logic [$clog2(`DMA_REG_DEPTH)-1:0] lookup_target,
    output      reg_write_t                        reg_write,
    output      logic [`DMA_CHANNEL_BITS-1:0]      n_channels,
    output      logic [15:0]                       program_size
);

    reg_command_t selected;
    logic         from_stream;
    logic         config_write;
    logic         register_write;

    // The stream has priority, a bus write in the same cycle is lost
    assign from_stream = stream_write.valid;
    assign selected = from_stream ? stream_write : bus_write;
    assign lookup_channel = selected.destination;

    // Word 0 on the bus is the program configuration, channel 0 on the stream is unused
    assign config_write = !from_stream && bus_write.valid && (bus_write.destination == '0);
    assign register_write = selected.valid && (selected.destination != '0);

    always_ff @(posedge clock) begin
        if (!reset) begin
            reg_write.valid <= 1'b0;
            n_channels <= '0;
            program_size <= '0;
        end else begin
            reg_write.valid <= register_write;
            if (config_write) begin
                n_channels <= bus_write.data[`DMA_CHANNEL_BITS-1:0];
                program_size <= bus_write.data[31:16];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (register_write) begin
            reg_write.address <= lookup_target;
            reg_write.data <= selected.data[`DMA_DATA_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

//--- src/io_translation_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "dma_endpoint_settings.svh"

module io_translation_table
    import dma_endpoint_pkg::*;
(
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire io_mapping_t                       io_mapping,
    input  wire logic [$clog2(`DMA_REG_DEPTH)-1:0] write_channel,
    output      logic [$clog2(`DMA_REG_DEPTH)-1:0] write_target,
    input  wire logic [$clog2(`DMA_REG_DEPTH)-1:0] read_channel,
    output      logic [$clog2(`DMA_REG_DEPTH)-1:0] read_target
);

    localparam int address_width = $clog2(`DMA_REG_DEPTH);

    logic [address_width-1:0] translation [`DMA_REG_DEPTH];

    // Every channel points at the register of the same number until remapped
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `DMA_REG_DEPTH; i++) begin
                translation[i] <= address_width'(i);
            end
        end else if (io_mapping.valid) begin
            translation[io_mapping.channel] <= io_mapping.target;
        end
    end

    // Both lookups are combinational so the users can register the result directly
    assign write_target = translation[write_channel];
    assign read_target = translation[read_channel];

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "dma_endpoint_settings.svh"

module register_file
    import dma_endpoint_pkg::*;
(
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire reg_write_t                        reg_write,
    input  wire logic [$clog2(`DMA_REG_DEPTH)-1:0] read_address,
    output      logic [`DMA_DATA_WIDTH-1:0]        read_data
);

    logic [`DMA_DATA_WIDTH-1:0] registers [`DMA_REG_DEPTH];

    // Stands in for the processor file, so it starts from a known zero state
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `DMA_REG_DEPTH; i++) begin
                registers[i] <= '0;
            end
        end else if (reg_write.valid) begin
            registers[reg_write.address] <= reg_write.data;
        end
    end

    assign read_data = registers[read_address];

endmodule

`default_nettype wire

//--- test/tb_dma_endpoint.sv
`timescale 1ns/100ps
`default_nettype none

`include "dma_endpoint_settings.svh"

module tb_dma_endpoint
    import dma_endpoint_pkg::*;
();

    localparam int address_width = $clog2(`DMA_REG_DEPTH);
    localparam int clock_period = 8;
    localparam int drive_delay = 1;
    localparam int random_ops = 200;
    localparam int ready_limit = 16;
    // Every operation takes about three cycles, directed ones and the final sweep included
    localparam int timeout_cycles = (40 + random_ops + `DMA_REG_DEPTH) * 4 + 200;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } expect_t;

    typedef struct packed {
        logic [`DMA_CHANNEL_BITS-1:0] n_channels;
        logic [15:0]                  program_size;
    } config_t;

    logic                         clock;
    logic                         reset;
    bus_request_t                 bus;
    bus_response_t                bus_response;
    io_mapping_t                  io_mapping;
    reg_command_t                 stream_write;
    read_request_t                read_request;
    logic                         read_request_ready;
    read_response_t               read_response;
    logic [`DMA_CHANNEL_BITS-1:0] n_channels;
    logic [15:0]                  program_size;

    // Reference model of the register file, the translation table and the configuration
    logic [`DMA_DATA_WIDTH-1:0] model_regs [`DMA_REG_DEPTH];
    logic [address_width-1:0]   model_table [`DMA_REG_DEPTH];
    config_t                    model_config;

    // Expected responses, marked in the cycle of the strobe or acceptance and delayed by two
    expect_t stream_mark;
    expect_t bus_mark;
    expect_t stream_pipe [2];
    expect_t bus_pipe [2];
    config_t config_pipe [2];

    int     error_count;
    int     op_count;
    integer seed;

    dma_endpoint_top u_dut (
        .clock              (clock),
        .reset              (reset),
        .bus                (bus),
        .bus_response       (bus_response),
        .io_mapping         (io_mapping),
        .stream_write       (stream_write),
        .read_request       (read_request),
        .read_request_ready (read_request_ready),
        .read_response      (read_response),
        .n_channels         (n_channels),
        .program_size       (program_size)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        if (!reset) begin
            stream_pipe[0] <= '0;
            stream_pipe[1] <= '0;
            bus_pipe[0] <= '0;
            bus_pipe[1] <= '0;
            config_pipe[0] <= '0;
            config_pipe[1] <= '0;
        end else begin
            stream_pipe[0] <= stream_mark;
            stream_pipe[1] <= stream_pipe[0];
            bus_pipe[0] <= bus_mark;
            bus_pipe[1] <= bus_pipe[0];
            config_pipe[0] <= model_config;
            config_pipe[1] <= config_pipe[0];
        end
    end

    // Outputs are checked at the falling edge, halfway between two updates
    assert property (@(negedge clock) disable iff (!reset)
        read_response.valid == stream_pipe[1].valid)
    else begin
        error_count++;
        $display("[FAIL] %0t read_response.valid expected %0b got %0b",
                 $time, stream_pipe[1].valid, read_response.valid);
    end

    assert property (@(negedge clock) disable iff (!reset)
        !stream_pipe[1].valid || read_response.data == stream_pipe[1].data[`DMA_DATA_WIDTH-1:0])
    else begin
        error_count++;
        $display("[FAIL] %0t read_response.data expected %h got %h",
                 $time, stream_pipe[1].data[`DMA_DATA_WIDTH-1:0], read_response.data);
    end

    assert property (@(negedge clock) disable iff (!reset)
        bus_response.valid == bus_pipe[1].valid)
    else begin
        error_count++;
        $display("[FAIL] %0t bus_response.valid expected %0b got %0b",
                 $time, bus_pipe[1].valid, bus_response.valid);
    end

    assert property (@(negedge clock) disable iff (!reset)
        !bus_pipe[1].valid || bus_response.data == bus_pipe[1].data)
    else begin
        error_count++;
        $display("[FAIL] %0t bus_response.data expected %h got %h",
                 $time, bus_pipe[1].data, bus_response.data);
    end

    // A stream read blocks new requests for two cycles, a bus read for its response cycle
    assert property (@(negedge clock) disable iff (!reset)
        read_request_ready == !(stream_pipe[0].valid || stream_pipe[1].valid || bus_pipe[1].valid))
    else begin
        error_count++;
        $display("[FAIL] %0t read_request_ready expected %0b got %0b", $time,
                 !(stream_pipe[0].valid || stream_pipe[1].valid || bus_pipe[1].valid),
                 read_request_ready);
    end

    assert property (@(negedge clock) disable iff (!reset)
        n_channels == config_pipe[1].n_channels && program_size == config_pipe[1].program_size)
    else begin
        error_count++;
        $display("[FAIL] %0t n_channels/program_size expected %h/%h got %h/%h", $time,
                 config_pipe[1].n_channels, config_pipe[1].program_size, n_channels, program_size);
    end

    function automatic logic in_window(input logic [31:0] address);
        return address >= `DMA_BASE_ADDRESS
            && address < `DMA_BASE_ADDRESS + 32'(4 * `DMA_REG_DEPTH);
    endfunction

    function automatic logic [address_width-1:0] word_of(input logic [31:0] address);
        logic [31:0] offset;
        offset = address - `DMA_BASE_ADDRESS;
        return offset[address_width+1:2];
    endfunction

    // Advances to the next drive point and drops all one-cycle strobes
    task automatic step();
        @(posedge clock);
        #drive_delay;
        bus.write_strobe = 1'b0;
        bus.read_strobe = 1'b0;
        stream_write.valid = 1'b0;
        read_request.valid = 1'b0;
        io_mapping.valid = 1'b0;
        stream_mark = '0;
        bus_mark = '0;
    endtask

    // Three cycles cover the longest write path and the longest read
    task automatic settle();
        repeat (3) step();
        op_count++;
    endtask

    task automatic write_stream(input logic [address_width-1:0] channel, input logic [31:0] data);
        stream_write.valid = 1'b1;
        stream_write.destination = channel;
        stream_write.data = data;
        if (channel != '0) begin
            model_regs[model_table[channel]] = data[`DMA_DATA_WIDTH-1:0];
        end
        settle();
    endtask

    task automatic write_bus(input logic [31:0] address, input logic [31:0] data);
        logic [address_width-1:0] word;
        word = word_of(address);
        bus.write_strobe = 1'b1;
        bus.address = address;
        bus.write_data = data;
        if (in_window(address) && word == '0) begin
            model_config.n_channels = data[`DMA_CHANNEL_BITS-1:0];
            model_config.program_size = data[31:16];
        end else if (in_window(address)) begin
            model_regs[model_table[word]] = data[`DMA_DATA_WIDTH-1:0];
        end
        settle();
    endtask

    task automatic map_channel(input logic [address_width-1:0] channel,
                               input logic [address_width-1:0] target);
        io_mapping.valid = 1'b1;
        io_mapping.channel = channel;
        io_mapping.target = target;
        model_table[channel] = target;
        settle();
    endtask

    task automatic read_bus(input logic [31:0] address);
        logic [address_width-1:0] word;
        word = word_of(address);
        bus.read_strobe = 1'b1;
        bus.address = address;
        bus_mark.valid = in_window(address);
        if (word == '0) begin
            bus_mark.data = {model_config.program_size, {(16 - `DMA_CHANNEL_BITS){1'b0}},
                             model_config.n_channels};
        end else begin
            bus_mark.data = 32'(model_regs[word]);
        end
        settle();
    endtask

    // The request is held until ready is seen high, then accepted at the next rising edge
    task automatic read_stream(input logic [address_width-1:0] channel);
        int waited;
        waited = 0;
        read_request.valid = 1'b1;
        read_request.channel = channel;
        @(negedge clock);
        while (!read_request_ready && waited < ready_limit) begin
            waited++;
            @(negedge clock);
        end
        if (!read_request_ready) begin
            error_count++;
            $display("Read request for channel %0d was never accepted", channel);
        end else if (channel != '0) begin
            stream_mark.valid = 1'b1;
            stream_mark.data = 32'(model_regs[model_table[channel]]);
        end
        settle();
    endtask

    task automatic random_operation();
        logic [31:0]              value;
        logic [31:0]              data;
        logic [address_width-1:0] channel;
        logic [31:0]              address;
        value = $random(seed);
        data = $random(seed);
        channel = value[13:8];
        address = `DMA_BASE_ADDRESS + 32'({channel, 2'b00});
        // About one bus access in eight lands just past the window
        if (value[18:16] == 3'd0) begin
            address = address + 32'(4 * `DMA_REG_DEPTH);
        end
        case (value[2:0])
            3'd0, 3'd1: write_stream(channel, data);
            3'd2: write_bus(address, data);
            3'd3, 3'd4: read_stream(channel);
            3'd5, 3'd6: read_bus(address);
            default: map_channel(channel, data[address_width-1:0]);
        endcase
    endtask

    initial begin
        seed = 32'hbb85;
        error_count = 0;
        op_count = 0;
        reset = 1'b0;
        bus = '0;
        io_mapping = '0;
        stream_write = '0;
        read_request = '0;
        stream_mark = '0;
        bus_mark = '0;
        model_config = '0;
        for (int i = 0; i < `DMA_REG_DEPTH; i++) begin
            model_regs[i] = '0;
            model_table[i] = address_width'(i);
        end
        repeat (3) @(posedge clock);
        #drive_delay;
        reset = 1'b1;

        write_stream(6'd3, 32'h000a_5c31);
        read_stream(6'd3);
        read_bus(`DMA_BASE_ADDRESS + 32'd12);

        // Channel 5 now lands in register 9, register 5 keeps its old value
        map_channel(6'd5, 6'd9);
        write_stream(6'd5, 32'h0003_1f07);
        read_bus(`DMA_BASE_ADDRESS + 32'd36);
        read_bus(`DMA_BASE_ADDRESS + 32'd20);
        read_stream(6'd5);

        write_bus(`DMA_BASE_ADDRESS, 32'h0123_0007);
        read_bus(`DMA_BASE_ADDRESS);

        write_stream(6'd0, 32'h000f_ffff);
        // Register 0 is only visible through a channel mapped onto it
        map_channel(6'd2, 6'd0);
        read_stream(6'd2);
        read_stream(6'd0);
        write_bus(`DMA_BASE_ADDRESS - 32'd4, 32'h0001_2345);
        read_bus(`DMA_BASE_ADDRESS + 32'(4 * (`DMA_REG_DEPTH - 1)));
        write_bus(`DMA_BASE_ADDRESS + 32'(4 * `DMA_REG_DEPTH), 32'h0005_4321);
        read_bus(`DMA_BASE_ADDRESS + 32'(4 * `DMA_REG_DEPTH));

        for (int n = 0; n < random_ops; n++) begin
            random_operation();
        end

        // A last sweep over every bus word catches writes that went to the wrong register
        for (int k = 0; k < `DMA_REG_DEPTH; k++) begin
            read_bus(`DMA_BASE_ADDRESS + 32'(4 * k));
        end

        $display("Operations: %0d, errors: %0d", op_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(timeout_cycles * clock_period);
        $display("Timeout after %0d cycles, the test sequence did not finish", timeout_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/dma_endpoint_pkg.sv
src/bus_register_front.sv
src/io_translation_table.sv
src/dma_write_router.sv
src/dma_read_sequencer.sv
src/register_file.sv
src/dma_endpoint_top.sv
test/tb_dma_endpoint.sv
